// File: compile.f
design/clmul_pkg.sv
design/clmul_ctrl.sv
design/limb_mul_serial.sv
design/limb_mul_array.sv
design/diag_accum.sv
design/clmul_top.sv
tb/clmul_tb.sv

// File: run.sh
#!/bin/sh
# Builds the carry-less multiplier testbench with Verilator and runs it.
# The result is taken from the simulation log.
set -e

cd "$(dirname "$0")"

LOG=sim.log

rm -rf obj_dir
verilator --binary --assert --top-module clmul_tb -f compile.f -o clmul_sim

# A failing run still leaves its log for the checks below
./obj_dir/clmul_sim > "$LOG" 2>&1 || true
cat "$LOG"

if grep -q "RESULT: FAIL" "$LOG"; then
	echo "simulation reported a failure, see $LOG"
	exit 1
fi

if ! grep -q "RESULT: PASS" "$LOG"; then
	echo "simulation ended without a result, see $LOG"
	exit 1
fi

exit 0

// File: tb/clmul_tb.sv
// Carry-less multiplier testbench
// Seeded random and corner operands through the req/ack handshake, each
// product checked against a bit-loop GF(2) model, plus latency,
// back-pressure and reset in the middle of a multiply
`timescale 1ns/1ps
`default_nettype none

module clmul_tb import clmul_pkg::*; ();

	localparam int LIMB_W     = LIMB_W_DEFAULT;
	localparam int CLK_PERIOD = 40;
	localparam int RST_CYCLES = 8;
	localparam int MAX_HOLD   = 20;
	localparam int N_RANDOM   = 200;

	// Boundary one-hot pairs, then the zero, all-ones and a = b cases
	localparam int N_BOUNDARY = 2 * LIMBS;
	localparam int N_CORNER   = N_BOUNDARY * N_BOUNDARY + 9;

	// Reset test plus the operation that follows it
	localparam int N_OPS = N_RANDOM + N_CORNER + 2;
	localparam int WATCHDOG_CYCLES =
		N_OPS * (LIMB_W + 3 + MAX_HOLD + 4) + RST_CYCLES + 100;

	logic  clk;
	logic  rst;
	logic  req;
	opnd_t a;
	opnd_t b;
	logic  ack;
	prod_t c;

	int ops_done;

	clmul_top #(
		.LIMB_W(LIMB_W)
	) dut0 (
		.clk (clk),
		.rst (rst),
		.req (req),
		.a   (a),
		.b   (b),
		.ack (ack),
		.c   (c)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#(CLK_PERIOD / 2) clk = ~clk;
		end
	end

	// Reports the failure and ends the run
	task automatic stop_run(input string why);
		$display("%s", why);
		$display("RESULT: FAIL");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_product(input prod_t got, input prod_t exp);
		if (got !== exp) begin
			stop_run($sformatf("Mismatch at %0t: c got %h expected %h", $time, got, exp));
		end
	endtask

	task automatic check_ack(input logic got, input logic exp);
		if (got !== exp) begin
			stop_run($sformatf("Mismatch at %0t: ack got %b expected %b", $time, got, exp));
		end
	endtask

	task automatic check_latency(input int got, input int exp);
		if (got != exp) begin
			stop_run($sformatf("Mismatch at %0t: ack latency got %0d expected %0d",
				$time, got, exp));
		end
	endtask

	// GF(2) product, b shifted by k wherever bit k of a is set
	function automatic prod_t clmul_model(input opnd_t x, input opnd_t y);
		prod_t r;
		r = '0;
		for (int k = 0; k < $bits(opnd_t); k++) begin
			if (x[k]) begin
				r = r ^ (prod_t'(y) << k);
			end
		end
		return r;
	endfunction

	function automatic opnd_t random_opnd();
		opnd_t v;
		v = '0;
		for (int k = 0; k < $bits(opnd_t); k += 32) begin
			v = (v << 32) | opnd_t'($urandom());
		end
		return v;
	endfunction

	// Lowest and highest bit of each limb
	function automatic int boundary_pos(input int n);
		return (n / 2) * LIMB_W + (n % 2) * (LIMB_W - 1);
	endfunction

	function automatic opnd_t one_hot(input int pos);
		return opnd_t'(1) << pos;
	endfunction

	// Entered and left 2 ns after a rising edge with ack low.
	// Outputs are sampled 1 ns after the edge.
	task automatic run_op(input opnd_t x, input opnd_t y);
		prod_t exp_c;
		int    edges;
		int    hold;
		exp_c = clmul_model(x, y);
		hold  = $urandom_range(MAX_HOLD, 0);
		a   = x;
		b   = y;
		req = 1'b1;
		// Edge at which the FSM sees req in idle
		@(posedge clk);
		edges = 0;
		do begin
			@(posedge clk);
			edges++;
			#1;
		end while (!ack);
		check_latency(edges, LIMB_W + 3);
		check_product(c, exp_c);
		#1;
		// Back-pressure, new operands must not be taken
		repeat (hold) begin
			a = random_opnd();
			b = random_opnd();
			@(posedge clk);
			#1;
			check_ack(ack, 1'b1);
			check_product(c, exp_c);
			#1;
		end
		req = 1'b0;
		@(posedge clk);
		#1;
		check_ack(ack, 1'b0);
		check_product(c, exp_c);
		#1;
		ops_done++;
	endtask

	task automatic run_random_ops();
		for (int n = 0; n < N_RANDOM; n++) begin
			run_op(random_opnd(), random_opnd());
		end
	endtask

	task automatic run_corner_ops();
		opnd_t ones;
		opnd_t r;
		ones = '1;
		run_op('0, '0);
		run_op('0, random_opnd());
		run_op(random_opnd(), '0);
		run_op(ones, ones);
		run_op(ones, random_opnd());
		run_op(ones, '0);
		// Every pair of limb edges lands on every diagonal
		for (int i = 0; i < N_BOUNDARY; i++) begin
			for (int j = 0; j < N_BOUNDARY; j++) begin
				run_op(one_hot(boundary_pos(i)), one_hot(boundary_pos(j)));
			end
		end
		for (int n = 0; n < 3; n++) begin
			r = random_opnd();
			run_op(r, r);
		end
	endtask

	// Reset lands in the middle of the serial multiply
	task automatic reset_mid_op();
		a   = random_opnd();
		b   = random_opnd();
		req = 1'b1;
		// Idle to load, then load to multiply
		@(posedge clk);
		@(posedge clk);
		repeat (LIMB_W / 2) @(posedge clk);
		#1;
		check_ack(ack, 1'b0);
		#1;
		rst = 1'b1;
		req = 1'b0;
		repeat (2) @(posedge clk);
		#1;
		check_ack(ack, 1'b0);
		check_product(c, '0);
		#1;
		rst = 1'b0;
		@(posedge clk);
		#1;
		check_ack(ack, 1'b0);
		check_product(c, '0);
		#1;
		ops_done++;
		run_op(random_opnd(), random_opnd());
	endtask

	initial begin
		void'($urandom(32'hd2e2));
		ops_done  = 0;
		rst = 1'b1;
		req = 1'b0;
		a   = '0;
		b   = '0;
		repeat (RST_CYCLES) @(posedge clk);
		#2;
		rst = 1'b0;
		@(posedge clk);
		#1;
		check_ack(ack, 1'b0);
		check_product(c, '0);
		#1;
		run_random_ops();
		run_corner_ops();
		reset_mid_op();
		$display("%0d operations checked with LIMB_W %0d", ops_done, LIMB_W);
		$display("RESULT: PASS");
		$finish;
	end

	// Bound on the whole run
	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		stop_run($sformatf("Timeout after %0d cycles, ack never arrived (%0d operations done)",
			WATCHDOG_CYCLES, ops_done));
	end

endmodule

`default_nettype wire

// File: design/clmul_top.sv
// Four-way split carry-less multiplier, top level
// GF(2) polynomial product of two operands behind a four-phase
// req/ack handshake
`timescale 1ns/1ps
`default_nettype none

module clmul_top import clmul_pkg::*; #(
	parameter int LIMB_W = LIMB_W_DEFAULT
) (
	input  logic  clk,
	input  logic  rst,
	input  logic  req,
	input  opnd_t a,
	input  opnd_t b,
	output logic  ack,
	output prod_t c
);

	logic                            load;
	logic                            accum_en;
	logic                            mul_done;
	logic [2*LIMBS*LIMBS*LIMB_W-1:0] pp;

	clmul_ctrl u_ctrl (
		.clk      (clk),
		.rst      (rst),
		.req      (req),
		.mul_done (mul_done),
		.load     (load),
		.accum_en (accum_en),
		.ack      (ack)
	);

	// Sixteen limb products in parallel
	limb_mul_array #(
		.LIMB_W(LIMB_W)
	) u_array (
		.clk      (clk),
		.rst      (rst),
		.load     (load),
		.a        (a),
		.b        (b),
		.pp       (pp),
		.mul_done (mul_done)
	);

	diag_accum #(
		.LIMB_W(LIMB_W)
	) u_accum (
		.clk      (clk),
		.rst      (rst),
		.accum_en (accum_en),
		.pp       (pp),
		.c        (c)
	);

endmodule

`default_nettype wire

// File: design/diag_accum.sv
// Diagonal XOR combiner
// Folds the sixteen limb products into the full product, each at offset
// (i + j) limbs, and registers the result on accum_en
`timescale 1ns/1ps
`default_nettype none

module diag_accum import clmul_pkg::*; #(
	parameter int LIMB_W = LIMB_W_DEFAULT
) (
	input  logic                              clk,
	input  logic                              rst,
	input  logic                              accum_en,
	input  logic [2*LIMBS*LIMBS*LIMB_W-1:0]   pp,
	output logic [2*LIMBS*LIMB_W-1:0]         c
);

	localparam int PP_W   = 2 * LIMB_W;
	localparam int PROD_W = 2 * LIMBS * LIMB_W;

	logic [PROD_W-1:0] sum;

	// Products on the same diagonal overlap and cancel bitwise
	always_comb begin
		sum = '0;
		for (int i = 0; i < LIMBS; i++) begin
			for (int j = 0; j < LIMBS; j++) begin
				sum = sum ^ (PROD_W'(pp[(i*LIMBS+j)*PP_W +: PP_W]) << ((i + j) * LIMB_W));
			end
		end
	end

	// Result held between operations
	always_ff @(posedge clk) begin
		if (rst) begin
			c <= '0;
		end else if (accum_en) begin
			c <= sum;
		end
	end

endmodule

`default_nettype wire

// File: design/limb_mul_array.sv
// Limb product array
// Registers both operands on load and runs one serial unit per limb
// pair (ai, bj); mul_done when all sixteen units have finished
`timescale 1ns/1ps
`default_nettype none

module limb_mul_array import clmul_pkg::*; #(
	parameter int LIMB_W = LIMB_W_DEFAULT
) (
	input  logic                              clk,
	input  logic                              rst,
	input  logic                              load,
	input  logic [LIMBS*LIMB_W-1:0]           a,
	input  logic [LIMBS*LIMB_W-1:0]           b,
	output logic [2*LIMBS*LIMBS*LIMB_W-1:0]   pp,
	output logic                              mul_done
);

	localparam int PP_W = 2 * LIMB_W;

	logic [LIMBS*LIMB_W-1:0] a_q;
	logic [LIMBS*LIMB_W-1:0] b_q;
	logic [LIMBS*LIMBS-1:0]  done_vec;
	logic                    in_flight;

	// Operand capture
	always_ff @(posedge clk) begin
		if (load) begin
			a_q <= a;
			b_q <= b;
		end
	end

	// Unit (i, j) forms ai * bj
	for (genvar i = 0; i < LIMBS; i++) begin : g_row
		for (genvar j = 0; j < LIMBS; j++) begin : g_col
			limb_mul_serial #(
				.LIMB_W(LIMB_W)
			) u_mul (
				.clk  (clk),
				.rst  (rst),
				.load (load),
				.x    (a_q[i*LIMB_W +: LIMB_W]),
				.y    (b_q[j*LIMB_W +: LIMB_W]),
				.p    (pp[(i*LIMBS+j)*PP_W +: PP_W]),
				.done (done_vec[i*LIMBS+j])
			);
		end
	end

	assign mul_done = &done_vec;

	// Tracks a multiply between load and completion
	always_ff @(posedge clk) begin
		if (rst) begin
			in_flight <= 1'b0;
		end else if (load) begin
			in_flight <= 1'b1;
		end else if (mul_done) begin
			in_flight <= 1'b0;
		end
	end

	// No reload while the units are still counting
	assert property (@(posedge clk) disable iff (rst)
		load |-> !in_flight);

endmodule

`default_nettype wire

// File: design/limb_mul_serial.sv
// Bit-serial carry-less limb multiplier
// Scans one bit of x per cycle and XORs the shifted y into the partial
// product; done after LIMB_W cycles
`timescale 1ns/1ps
`default_nettype none

module limb_mul_serial import clmul_pkg::*; #(
	parameter int LIMB_W = LIMB_W_DEFAULT
) (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  load,
	input  logic [LIMB_W-1:0]     x,
	input  logic [LIMB_W-1:0]     y,
	output logic [2*LIMB_W-1:0]   p,
	output logic                  done
);

	localparam int CNT_W = $clog2(LIMB_W + 1);
	localparam int IDX_W = (LIMB_W > 1) ? $clog2(LIMB_W) : 1;
	localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(LIMB_W - 1);
	localparam logic [CNT_W-1:0] CNT_MAX = CNT_W'(LIMB_W);

	logic [CNT_W-1:0]    cnt;
	logic                run;
	logic [2*LIMB_W-1:0] y_ext;

	assign y_ext = {{LIMB_W{1'b0}}, y};

	// Bit counter, parks at LIMB_W
	always_ff @(posedge clk) begin
		if (rst) begin
			cnt <= '0;
			run <= 1'b0;
		end else if (load) begin
			cnt <= '0;
			run <= 1'b1;
		end else if (run) begin
			cnt <= cnt + 1'b1;
			run <= (cnt != CNT_LAST);
		end
	end

	always_ff @(posedge clk) begin
		if (load) begin
			p <= '0;
		end else if (run && x[cnt[IDX_W-1:0]]) begin
			p <= p ^ (y_ext << cnt);
		end
	end

	assign done = (cnt == CNT_MAX);

	// Once finished the counter stays put until reloaded
	assert property (@(posedge clk) disable iff (rst)
		(cnt == CNT_MAX) && !load |=> (cnt == CNT_MAX));

endmodule

`default_nettype wire

// File: design/clmul_ctrl.sv
// Carry-less multiplier control
// Runs the four-phase req/ack handshake and sequences one product:
// operand load, serial multiply, diagonal accumulate, then ack
`timescale 1ns/1ps
`default_nettype none

module clmul_ctrl import clmul_pkg::*; (
	input  logic clk,
	input  logic rst,
	input  logic req,
	input  logic mul_done,
	output logic load,
	output logic accum_en,
	output logic ack
);

	ctrl_state_t state;
	ctrl_state_t state_nxt;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= ST_IDLE;
		end else begin
			state <= state_nxt;
		end
	end

	always_comb begin
		state_nxt = state;
		case (state)
			ST_IDLE: begin
				// New request accepted only from idle
				if (req) begin
					state_nxt = ST_LOAD;
				end
			end
			ST_LOAD: begin
				state_nxt = ST_MULT;
			end
			ST_MULT: begin
				// Wait for all sixteen limb units
				if (mul_done) begin
					state_nxt = ST_ACCUM;
				end
			end
			ST_ACCUM: begin
				state_nxt = ST_ACK;
			end
			ST_ACK: begin
				// Hold ack and product until the requester lets go
				if (!req) begin
					state_nxt = ST_IDLE;
				end
			end
			default: begin
				state_nxt = ST_IDLE;
			end
		endcase
	end

	// Strobes decoded from state
	assign load     = (state == ST_LOAD);
	assign accum_en = (state == ST_ACCUM);
	assign ack      = (state == ST_ACK);

	// ack only drops after the requester has released req
	assert property (@(posedge clk) disable iff (rst)
		$fell(ack) |-> ($past(req) == 1'b0));

	// Units restart on load, so a stale done never skips the multiply
	assert property (@(posedge clk) disable iff (rst)
		load |=> !mul_done);

	// Requester must wait for ack low before the next req
	assert property (@(posedge clk) disable iff (rst)
		$rose(req) |-> !ack);

endmodule

`default_nettype wire

// File: design/clmul_pkg.sv
// Carry-less multiplier shared definitions
// Limb split factor, default limb width, operand and product types and
// the control state encoding
`default_nettype none

package clmul_pkg;

	// Split factor of the schoolbook algorithm
	localparam int LIMBS = 4;

	// Default limb width, 64-bit operands
	localparam int LIMB_W_DEFAULT = 16;

	typedef logic [LIMBS*LIMB_W_DEFAULT-1:0] opnd_t;
	typedef logic [2*LIMBS*LIMB_W_DEFAULT-1:0] prod_t;

	// Control FSM states
	typedef enum logic [2:0] {
		ST_IDLE,
		ST_LOAD,
		ST_MULT,
		ST_ACCUM,
		ST_ACK
	} ctrl_state_t;

endpackage

`default_nettype wire
